// ==== design/dispatch_pkg.sv ====
package dispatch_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int gpr_num        = 32;
    localparam int issue_width    = 2;
    localparam int csr_addr_width = 14;

    // ALU operation code
    typedef logic [7:0] aluop_t;

    // CSR access ops, any CSR op other than a read writes the CSR
    localparam aluop_t csr_read_op  = 8'h30;
    localparam aluop_t csr_write_op = 8'h31;

    // Any flag set makes the instruction single issue
    typedef struct packed {
        logic is_mem;
        logic is_csr;
        logic is_pri;
        logic excp;
    } instr_class_t;

    // CSR number sits in the low bits of the immediate
    typedef struct packed {
        logic [data_width-csr_addr_width-1:0] csr_pad;
        logic [csr_addr_width-1:0]            csr_num;
    } csr_field_t;

    typedef union packed {
        logic [data_width-1:0] value;
        csr_field_t            csr;
    } imm_word_u;

endpackage

// ==== design/dispatch_if.sv ====
`timescale 1ns/100ps

// Issue decision from the checker to the issue register
interface issue_decision_if;
    import dispatch_pkg::*;

    logic [issue_width-1:0]                     issue_valid;
    logic [issue_width-1:0]                     csr_we;
    logic [issue_width-1:0][csr_addr_width-1:0] csr_addr;

    modport source (output issue_valid, output csr_we, output csr_addr);
    modport sink   (input issue_valid, input csr_we, input csr_addr);
endinterface

// Collected source operands per slot
interface operand_if;
    import dispatch_pkg::*;

    logic [issue_width-1:0][data_width-1:0] src1;
    logic [issue_width-1:0][data_width-1:0] src2;

    modport source (output src1, output src2);
    modport sink   (input src1, input src2);
endinterface

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic clk,
    input  logic rst_n,
    input  logic [2*dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rd_addr_i,
    output logic [2*dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     rd_data_o,
    input  logic [dispatch_pkg::issue_width-1:0]                                     wr_en_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0]   wr_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]       wr_data_i
);
    import dispatch_pkg::*;

    logic [data_width-1:0] regs [gpr_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < gpr_num; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Lane 1 comes last so it wins a same-address clash
            for (int l = 0; l < issue_width; l++) begin
                if (wr_en_i[l] && wr_addr_i[l] != '0) begin
                    regs[wr_addr_i[l]] <= wr_data_i[l];
                end
            end
        end
    end

    // Old value is seen during a write
    always_comb begin
        for (int p = 0; p < 2 * issue_width; p++) begin
            rd_data_o[p] = regs[rd_addr_i[p]];
        end
    end

endmodule

// ==== design/issue_checker.sv ====
`timescale 1ns/100ps

module issue_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  logic flush_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   valid_i,
    input  dispatch_pkg::instr_class_t [dispatch_pkg::issue_width-1:0]             class_i,
    input  dispatch_pkg::aluop_t [dispatch_pkg::issue_width-1:0]                   aluop_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rj_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rk_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rj_re_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rk_re_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rd_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rd_we_i,
    input  dispatch_pkg::imm_word_u [dispatch_pkg::issue_width-1:0]                imm_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   ex_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] ex_fwd_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   wb_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] wb_fwd_addr_i,
    output logic [dispatch_pkg::issue_width-1:0]                                   accept_o,
    issue_decision_if.source                                                       dec
);
    import dispatch_pkg::*;

    logic [gpr_num-1:0]     reg_ready;
    logic [issue_width-1:0] src_ready;
    logic [issue_width-1:0] issue;
    logic                   single_issue;
    logic                   raw_dep;

    // Only sources that are actually read need to be ready
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            src_ready[i] = (!rj_re_i[i] || reg_ready[rj_i[i]]) &&
                           (!rk_re_i[i] || reg_ready[rk_i[i]]);
        end
    end

    always_comb begin
        single_issue = 1'b0;
        for (int i = 0; i < issue_width; i++) begin
            single_issue |= class_i[i].is_mem | class_i[i].is_csr |
                            class_i[i].is_pri | class_i[i].excp;
        end
    end

    // Slot 1 reading what slot 0 writes
    assign raw_dep = rd_we_i[0] && rd_i[0] != '0 &&
                     ((rj_re_i[1] && rj_i[1] == rd_i[0]) ||
                      (rk_re_i[1] && rk_i[1] == rd_i[0]));

    assign issue[0] = valid_i[0] && src_ready[0];
    assign issue[1] = valid_i[1] && src_ready[1] && issue[0] && !single_issue && !raw_dep;

    // Empty slot is taken only behind accepted slots
    assign accept_o[0] = !stall_i && (issue[0] || !valid_i[0]);
    assign accept_o[1] = !stall_i && (issue[1] || (!valid_i[1] && (issue[0] || !valid_i[0])));

    always_comb begin
        dec.issue_valid = issue;
        for (int i = 0; i < issue_width; i++) begin
            dec.csr_we[i]   = class_i[i].is_csr && aluop_i[i] != csr_read_op;
            dec.csr_addr[i] = imm_i[i].csr.csr_num;
        end
    end

    // Scoreboard, r0 is never cleared so it stays ready
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            reg_ready <= '1;
        end else if (!stall_i) begin
            for (int l = 0; l < issue_width; l++) begin
                if (ex_fwd_valid_i[l]) reg_ready[ex_fwd_addr_i[l]] <= 1'b1;
                if (wb_fwd_valid_i[l]) reg_ready[wb_fwd_addr_i[l]] <= 1'b1;
            end
            // Clear after set so a new writer wins
            for (int i = 0; i < issue_width; i++) begin
                if (issue[i] && rd_we_i[i] && rd_i[i] != '0) begin
                    reg_ready[rd_i[i]] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== design/operand_collector.sv ====
`timescale 1ns/100ps

module operand_collector (
    operand_if.source                                                              opnd,
    output logic [2*dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rf_addr_o,
    input  logic [2*dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]   rf_data_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rj_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rk_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   use_imm_i,
    input  dispatch_pkg::imm_word_u [dispatch_pkg::issue_width-1:0]                imm_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   ex_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] ex_fwd_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     ex_fwd_data_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   wb_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] wb_fwd_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     wb_fwd_data_i
);
    import dispatch_pkg::*;

    // Read port 2i is rj of slot i, port 2i+1 is rk
    logic [2*issue_width-1:0][reg_addr_width-1:0] src_addr;
    logic [2*issue_width-1:0][data_width-1:0]     src_val;

    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            src_addr[2*i]   = rj_i[i];
            src_addr[2*i+1] = rk_i[i];
        end
    end

    assign rf_addr_o = src_addr;

    // Later overrides win, so WB beats the regfile and EX beats WB
    always_comb begin
        for (int p = 0; p < 2 * issue_width; p++) begin
            src_val[p] = rf_data_i[p];
            for (int l = 0; l < issue_width; l++) begin
                if (wb_fwd_valid_i[l] && wb_fwd_addr_i[l] == src_addr[p]) begin
                    src_val[p] = wb_fwd_data_i[l];
                end
            end
            for (int l = 0; l < issue_width; l++) begin
                if (ex_fwd_valid_i[l] && ex_fwd_addr_i[l] == src_addr[p]) begin
                    src_val[p] = ex_fwd_data_i[l];
                end
            end
            // r0 reads zero even if forwarded
            if (src_addr[p] == '0) src_val[p] = '0;
        end
    end

    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            opnd.src1[i] = src_val[2*i];
            opnd.src2[i] = use_imm_i[i] ? imm_i[i].value : src_val[2*i+1];
        end
    end

endmodule

// ==== design/issue_register.sv ====
`timescale 1ns/100ps

module issue_register (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  logic flush_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     pc_i,
    input  dispatch_pkg::aluop_t [dispatch_pkg::issue_width-1:0]                   aluop_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rd_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rd_we_i,
    issue_decision_if.sink                                                         dec,
    operand_if.sink                                                                opnd,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_valid_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_pc_o,
    output dispatch_pkg::aluop_t [dispatch_pkg::issue_width-1:0]                   out_aluop_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] out_rd_o,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_rd_we_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_src1_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_src2_o,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_csr_we_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::csr_addr_width-1:0] out_csr_addr_o
);
    import dispatch_pkg::*;

    // Control bits, only issuing slots may assert them
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            out_valid_o  <= '0;
            out_rd_we_o  <= '0;
            out_csr_we_o <= '0;
        end else if (!stall_i) begin
            out_valid_o  <= dec.issue_valid;
            out_rd_we_o  <= rd_we_i & dec.issue_valid;
            out_csr_we_o <= dec.csr_we & dec.issue_valid;
        end
    end

    // Payload, zeroed for slots that do not issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_width; i++) begin
            if (flush_i || (!stall_i && !dec.issue_valid[i])) begin
                out_pc_o[i]       <= '0;
                out_aluop_o[i]    <= '0;
                out_rd_o[i]       <= '0;
                out_src1_o[i]     <= '0;
                out_src2_o[i]     <= '0;
                out_csr_addr_o[i] <= '0;
            end else if (!stall_i) begin
                out_pc_o[i]       <= pc_i[i];
                out_aluop_o[i]    <= aluop_i[i];
                out_rd_o[i]       <= rd_i[i];
                out_src1_o[i]     <= opnd.src1[i];
                out_src2_o[i]     <= opnd.src2[i];
                out_csr_addr_o[i] <= dec.csr_addr[i];
            end
        end
    end

endmodule

// ==== design/dispatch_top.sv ====
`timescale 1ns/100ps

module dispatch_top (
    input  logic clk,
    input  logic rst_n,
    input  logic [dispatch_pkg::issue_width-1:0]                                   valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     pc_i,
    input  dispatch_pkg::aluop_t [dispatch_pkg::issue_width-1:0]                   aluop_i,
    input  dispatch_pkg::instr_class_t [dispatch_pkg::issue_width-1:0]             class_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rj_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rk_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rj_re_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rk_re_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] rd_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   rd_we_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   use_imm_i,
    input  dispatch_pkg::imm_word_u [dispatch_pkg::issue_width-1:0]                imm_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   ex_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] ex_fwd_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     ex_fwd_data_i,
    input  logic [dispatch_pkg::issue_width-1:0]                                   wb_fwd_valid_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] wb_fwd_addr_i,
    input  logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     wb_fwd_data_i,
    input  logic stall_i,
    input  logic flush_i,
    output logic [dispatch_pkg::issue_width-1:0]                                   accept_o,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_valid_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_pc_o,
    output dispatch_pkg::aluop_t [dispatch_pkg::issue_width-1:0]                   out_aluop_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::reg_addr_width-1:0] out_rd_o,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_rd_we_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_src1_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0]     out_src2_o,
    output logic [dispatch_pkg::issue_width-1:0]                                   out_csr_we_o,
    output logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::csr_addr_width-1:0] out_csr_addr_o
);
    import dispatch_pkg::*;

    logic [2*issue_width-1:0][reg_addr_width-1:0] rf_addr;
    logic [2*issue_width-1:0][data_width-1:0]     rf_data;

    issue_decision_if dec_if ();
    operand_if        opnd_if ();

    // WB lanes double as the regfile write ports
    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_i (rf_addr),
        .rd_data_o (rf_data),
        .wr_en_i   (wb_fwd_valid_i),
        .wr_addr_i (wb_fwd_addr_i),
        .wr_data_i (wb_fwd_data_i)
    );

    issue_checker u_issue_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .valid_i        (valid_i),
        .class_i        (class_i),
        .aluop_i        (aluop_i),
        .rj_i           (rj_i),
        .rk_i           (rk_i),
        .rj_re_i        (rj_re_i),
        .rk_re_i        (rk_re_i),
        .rd_i           (rd_i),
        .rd_we_i        (rd_we_i),
        .imm_i          (imm_i),
        .ex_fwd_valid_i (ex_fwd_valid_i),
        .ex_fwd_addr_i  (ex_fwd_addr_i),
        .wb_fwd_valid_i (wb_fwd_valid_i),
        .wb_fwd_addr_i  (wb_fwd_addr_i),
        .accept_o       (accept_o),
        .dec            (dec_if.source)
    );

    operand_collector u_operand_collector (
        .opnd           (opnd_if.source),
        .rf_addr_o      (rf_addr),
        .rf_data_i      (rf_data),
        .rj_i           (rj_i),
        .rk_i           (rk_i),
        .use_imm_i      (use_imm_i),
        .imm_i          (imm_i),
        .ex_fwd_valid_i (ex_fwd_valid_i),
        .ex_fwd_addr_i  (ex_fwd_addr_i),
        .ex_fwd_data_i  (ex_fwd_data_i),
        .wb_fwd_valid_i (wb_fwd_valid_i),
        .wb_fwd_addr_i  (wb_fwd_addr_i),
        .wb_fwd_data_i  (wb_fwd_data_i)
    );

    issue_register u_issue_register (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .pc_i           (pc_i),
        .aluop_i        (aluop_i),
        .rd_i           (rd_i),
        .rd_we_i        (rd_we_i),
        .dec            (dec_if.sink),
        .opnd           (opnd_if.sink),
        .out_valid_o    (out_valid_o),
        .out_pc_o       (out_pc_o),
        .out_aluop_o    (out_aluop_o),
        .out_rd_o       (out_rd_o),
        .out_rd_we_o    (out_rd_we_o),
        .out_src1_o     (out_src1_o),
        .out_src2_o     (out_src2_o),
        .out_csr_we_o   (out_csr_we_o),
        .out_csr_addr_o (out_csr_addr_o)
    );

endmodule

// ==== tb/dispatch_properties.sv ====
`timescale 1ns/100ps

module dispatch_properties (
    input logic clk,
    input logic rst_n,
    input logic stall_i,
    input logic flush_i,
    input logic [dispatch_pkg::issue_width-1:0]                               out_valid_o,
    input logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0] out_pc_o,
    input logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0] out_src1_o,
    input logic [dispatch_pkg::issue_width-1:0][dispatch_pkg::data_width-1:0] out_src2_o
);
    // Nothing is valid right after reset or flush
    a_clear: assert property (@(posedge clk) (!rst_n || flush_i) |=> out_valid_o == '0)
        else $error("issue port valid after reset or flush");

    // Stall freezes the issue port
    a_stall: assert property (@(posedge clk)
        (rst_n && stall_i && !flush_i) |=>
            ($stable(out_valid_o) && $stable(out_pc_o) &&
             $stable(out_src1_o) && $stable(out_src2_o)))
        else $error("issue port changed during stall");

    // In-order issue never leaves a hole in slot 0
    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o[1] |-> out_valid_o[0])
        else $error("slot 1 valid without slot 0");
endmodule

bind issue_register dispatch_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .out_valid_o (out_valid_o),
    .out_pc_o    (out_pc_o),
    .out_src1_o  (out_src1_o),
    .out_src2_o  (out_src2_o)
);

// ==== tb/tb_dispatch.sv ====
`timescale 1ns/100ps

module tb_dispatch;
    import dispatch_pkg::*;

    localparam int test_cycles = 80;

    logic clk, rst_n, stall, flush;
    logic [issue_width-1:0] valid, rj_re, rk_re, rd_we, use_imm, ex_v, wb_v;
    logic [issue_width-1:0][data_width-1:0] pc, ex_d, wb_d;
    logic [issue_width-1:0][reg_addr_width-1:0] rj, rk, rd, ex_a, wb_a;
    aluop_t [issue_width-1:0] aluop;
    instr_class_t [issue_width-1:0] cls;
    imm_word_u [issue_width-1:0] imm;

    logic [issue_width-1:0] accept, out_valid, out_rd_we, out_csr_we;
    logic [issue_width-1:0][data_width-1:0] out_pc, out_src1, out_src2;
    logic [issue_width-1:0][reg_addr_width-1:0] out_rd;
    logic [issue_width-1:0][csr_addr_width-1:0] out_csr_addr;
    aluop_t [issue_width-1:0] out_aluop;

    // Reference model state
    logic [data_width-1:0] ref_rf [gpr_num];
    logic [gpr_num-1:0] ref_ready;
    logic [issue_width-1:0] m_valid, m_rd_we, m_csr_we;
    logic [issue_width-1:0][data_width-1:0] m_pc, m_src1, m_src2;
    logic [issue_width-1:0][reg_addr_width-1:0] m_rd;
    aluop_t [issue_width-1:0] m_aluop;
    csr_field_t m_csr [issue_width];
    logic [31:0] lcg_state = 32'haaad;

    dispatch_top dut (
        .clk(clk), .rst_n(rst_n), .valid_i(valid), .pc_i(pc), .aluop_i(aluop),
        .class_i(cls), .rj_i(rj), .rk_i(rk), .rj_re_i(rj_re), .rk_re_i(rk_re),
        .rd_i(rd), .rd_we_i(rd_we), .use_imm_i(use_imm), .imm_i(imm),
        .ex_fwd_valid_i(ex_v), .ex_fwd_addr_i(ex_a), .ex_fwd_data_i(ex_d),
        .wb_fwd_valid_i(wb_v), .wb_fwd_addr_i(wb_a), .wb_fwd_data_i(wb_d),
        .stall_i(stall), .flush_i(flush), .accept_o(accept),
        .out_valid_o(out_valid), .out_pc_o(out_pc), .out_aluop_o(out_aluop),
        .out_rd_o(out_rd), .out_rd_we_o(out_rd_we), .out_src1_o(out_src1),
        .out_src2_o(out_src2), .out_csr_we_o(out_csr_we), .out_csr_addr_o(out_csr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(test_cycles * 4 + 200);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail %s: got %h expected %h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_accept(input logic [issue_width-1:0] got,
                                input logic [issue_width-1:0] exp);
        if (got !== exp) fail_value("accept_o", 32'(got), 32'(exp));
    endtask

    task automatic check_issue_slot(input int s, input aluop_t got_op, input aluop_t exp_op,
                                    input logic [data_width-1:0] got_s1,
                                    input logic [data_width-1:0] exp_s1,
                                    input logic [data_width-1:0] got_s2,
                                    input logic [data_width-1:0] exp_s2);
        if (out_valid[s] !== m_valid[s])
            fail_value($sformatf("out_valid_o[%0d]", s), 32'(out_valid[s]), 32'(m_valid[s]));
        if (out_pc[s] !== m_pc[s])
            fail_value($sformatf("out_pc_o[%0d]", s), out_pc[s], m_pc[s]);
        if (got_op !== exp_op)
            fail_value($sformatf("out_aluop_o[%0d]", s), 32'(got_op), 32'(exp_op));
        if (out_rd[s] !== m_rd[s] || out_rd_we[s] !== m_rd_we[s])
            fail_value($sformatf("out_rd_o/out_rd_we_o[%0d]", s),
                       {26'h0, out_rd_we[s], out_rd[s]}, {26'h0, m_rd_we[s], m_rd[s]});
        if (got_s1 !== exp_s1)
            fail_value($sformatf("out_src1_o[%0d]", s), got_s1, exp_s1);
        if (got_s2 !== exp_s2)
            fail_value($sformatf("out_src2_o[%0d]", s), got_s2, exp_s2);
    endtask

    task automatic check_csr(input int s, input logic got_we, input logic exp_we,
                             input csr_field_t got, input csr_field_t exp);
        if (got_we !== exp_we)
            fail_value($sformatf("out_csr_we_o[%0d]", s), 32'(got_we), 32'(exp_we));
        if (got !== exp)
            fail_value($sformatf("out_csr_addr_o[%0d]", s), 32'(got), 32'(exp));
    endtask

    task automatic check_outputs();
        csr_field_t g;
        for (int i = 0; i < issue_width; i++) begin
            check_issue_slot(i, out_aluop[i], m_aluop[i], out_src1[i], m_src1[i],
                             out_src2[i], m_src2[i]);
            g.csr_pad = '0;
            g.csr_num = out_csr_addr[i];
            check_csr(i, out_csr_we[i], m_csr_we[i], g, m_csr[i]);
        end
    endtask

    // EX lane 1, EX lane 0, WB lane 1, WB lane 0, then the register file
    function automatic logic [data_width-1:0] expect_src(input logic [reg_addr_width-1:0] a);
        if (a == '0) return '0;
        if (ex_v[1] && ex_a[1] == a) return ex_d[1];
        if (ex_v[0] && ex_a[0] == a) return ex_d[0];
        if (wb_v[1] && wb_a[1] == a) return wb_d[1];
        if (wb_v[0] && wb_a[0] == a) return wb_d[0];
        return ref_rf[a];
    endfunction

    task automatic clear_model();
        m_valid = '0;
        m_rd_we = '0;
        m_csr_we = '0;
        m_pc = '0;
        m_src1 = '0;
        m_src2 = '0;
        m_rd = '0;
        m_aluop = '0;
        for (int i = 0; i < issue_width; i++) m_csr[i] = '0;
        ref_ready = '1;
    endtask

    task automatic clear_inputs();
        {valid, rj_re, rk_re, rd_we, use_imm, ex_v, wb_v} = '0;
        {pc, ex_d, wb_d, rj, rk, rd, ex_a, wb_a} = '0;
        aluop = '0;
        cls = '0;
        imm = '0;
    endtask

    task automatic set_slot(input int s, input logic [31:0] p, input aluop_t op,
                            input instr_class_t c, input logic [4:0] j, input logic [4:0] k,
                            input logic je, input logic ke, input logic [4:0] d,
                            input logic dwe, input logic ui, input logic [31:0] iv);
        valid[s] = 1'b1;
        pc[s] = p;
        aluop[s] = op;
        cls[s] = c;
        rj[s] = j;
        rk[s] = k;
        rj_re[s] = je;
        rk_re[s] = ke;
        rd[s] = d;
        rd_we[s] = dwe;
        use_imm[s] = ui;
        imm[s].value = iv;
    endtask

    // Called on a falling edge, returns on the next falling edge
    task automatic run_cycle(input logic [issue_width-1:0] exp_acc);
        logic [issue_width-1:0] iss;
        logic [data_width-1:0] s1 [issue_width];
        logic [data_width-1:0] s2 [issue_width];
        #1;
        check_accept(accept, exp_acc);
        iss = exp_acc & valid & {issue_width{!stall}};
        for (int i = 0; i < issue_width; i++) begin
            if (iss[i] && ((rj_re[i] && !ref_ready[rj[i]]) ||
                           (rk_re[i] && !ref_ready[rk[i]]))) begin
                $display("Slot %0d was accepted although a source is still busy", i);
                $display("TEST FAILED");
                $fatal(1);
            end
            s1[i] = expect_src(rj[i]);
            s2[i] = use_imm[i] ? imm[i].value : expect_src(rk[i]);
        end
        @(posedge clk);
        for (int l = 0; l < issue_width; l++) begin
            if (wb_v[l] && wb_a[l] != '0) ref_rf[wb_a[l]] = wb_d[l];
        end
        if (flush) begin
            clear_model();
        end else if (!stall) begin
            for (int l = 0; l < issue_width; l++) begin
                if (ex_v[l]) ref_ready[ex_a[l]] = 1'b1;
                if (wb_v[l]) ref_ready[wb_a[l]] = 1'b1;
            end
            for (int i = 0; i < issue_width; i++) begin
                m_valid[i] = iss[i];
                m_pc[i] = iss[i] ? pc[i] : '0;
                m_aluop[i] = iss[i] ? aluop[i] : '0;
                m_rd[i] = iss[i] ? rd[i] : '0;
                m_rd_we[i] = iss[i] & rd_we[i];
                m_src1[i] = iss[i] ? s1[i] : '0;
                m_src2[i] = iss[i] ? s2[i] : '0;
                m_csr_we[i] = iss[i] && cls[i].is_csr && aluop[i] != csr_read_op;
                m_csr[i].csr_pad = '0;
                m_csr[i].csr_num = iss[i] ? imm[i].csr.csr_num : '0;
                if (iss[i] && rd_we[i] && rd[i] != '0) ref_ready[rd[i]] = 1'b0;
            end
        end
        @(negedge clk);
        check_outputs();
    endtask

    task automatic reset_dut();
        clear_inputs();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        for (int r = 0; r < gpr_num; r++) ref_rf[r] = '0;
        clear_model();
        @(negedge clk);
        rst_n = 1'b1;
        check_outputs();
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        wb_v[0] = 1'b1;
        wb_a[0] = a;
        wb_d[0] = d;
        run_cycle(2'b11);
        wb_v = '0;
    endtask

    initial begin
        instr_class_t alu_c, csr_c, mem_c;
        logic [4:0] a, b, c, d;
        alu_c = '0;
        csr_c = '0;
        csr_c.is_csr = 1'b1;
        mem_c = '0;
        mem_c.is_mem = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        rst_n = 1'b0;
        clear_inputs();
        @(negedge clk);
        reset_dut();
        a = 5'd1 + 5'(lcg_next() % 7);
        b = 5'd8 + 5'(lcg_next() % 8);
        c = 5'd16 + 5'(lcg_next() % 8);
        d = 5'd24 + 5'(lcg_next() % 4);

        // Independent ALU pair on written registers
        write_reg(a, lcg_next());
        write_reg(b, lcg_next());
        write_reg(c, lcg_next());
        write_reg(d, lcg_next());
        set_slot(0, 32'h100, 8'h01, alu_c, a, b, 1, 1, 5'd28, 1, 0, 0);
        set_slot(1, 32'h104, 8'h02, alu_c, c, d, 1, 1, 5'd29, 1, 0, 0);
        run_cycle(2'b11);
        clear_inputs();
        run_cycle(2'b11);

        // Dependent pair, then single-issue classes
        set_slot(0, 32'h108, 8'h01, alu_c, b, 5'd0, 1, 0, a, 1, 0, 0);
        set_slot(1, 32'h10c, 8'h02, alu_c, a, 5'd0, 1, 0, 5'd0, 0, 0, 0);
        run_cycle(2'b01);
        set_slot(0, 32'h200, csr_write_op, csr_c, b, 5'd0, 1, 0, 5'd0, 0, 0,
                 {18'h0, 14'(lcg_next())});
        set_slot(1, 32'h204, 8'h03, alu_c, c, d, 1, 1, 5'd0, 0, 0, 0);
        run_cycle(2'b01);
        set_slot(0, 32'h208, 8'h10, mem_c, b, 5'd0, 1, 0, 5'd0, 0, 0, 0);
        run_cycle(2'b01);
        // CSR read keeps csr_we low
        set_slot(0, 32'h20c, csr_read_op, csr_c, 5'd0, 5'd0, 0, 0, 5'd0, 0, 0,
                 {18'h0, 14'(lcg_next())});
        run_cycle(2'b01);
        clear_inputs();
        flush = 1'b1;
        run_cycle(2'b11);
        flush = 1'b0;

        // Scoreboard blocks a read until EX reports the register
        set_slot(0, 32'h300, 8'h04, alu_c, 5'd0, 5'd0, 0, 0, c, 1, 0, 0);
        run_cycle(2'b11);
        clear_inputs();
        set_slot(0, 32'h304, 8'h05, alu_c, c, 5'd0, 1, 0, 5'd0, 0, 0, 0);
        run_cycle(2'b00);
        ex_v[0] = 1'b1;
        ex_a[0] = c;
        ex_d[0] = lcg_next();
        run_cycle(2'b00);
        ex_v = '0;
        run_cycle(2'b11);

        // Forwarding priority, r0 and immediate
        clear_inputs();
        set_slot(0, 32'h400, 8'h06, alu_c, b, d, 1, 1, 5'd0, 0, 0, 0);
        set_slot(1, 32'h404, 8'h07, alu_c, 5'd0, b, 1, 1, 5'd0, 0, 1, lcg_next());
        ex_v = 2'b11;
        ex_a = {b, b};
        ex_d = {lcg_next(), lcg_next()};
        wb_v = 2'b11;
        wb_a = {d, b};
        wb_d = {lcg_next(), lcg_next()};
        run_cycle(2'b11);
        clear_inputs();
        set_slot(0, 32'h408, 8'h08, alu_c, 5'd0, 5'd0, 1, 1, 5'd0, 0, 0, 0);
        ex_v[0] = 1'b1;
        ex_d[0] = 32'hffff_ffff;
        run_cycle(2'b11);

        // Stall holds, flush clears and frees the scoreboard
        clear_inputs();
        set_slot(0, 32'h500, 8'h09, alu_c, a, 5'd0, 1, 0, 5'd12, 1, 0, 0);
        set_slot(1, 32'h504, 8'h0a, alu_c, c, d, 1, 1, 5'd0, 0, 0, 0);
        run_cycle(2'b11);
        stall = 1'b1;
        clear_inputs();
        set_slot(0, 32'h508, 8'h0b, alu_c, b, 5'd0, 1, 0, 5'd0, 0, 0, 0);
        run_cycle(2'b00);
        stall = 1'b0;
        // Held slot would issue here without the flush
        flush = 1'b1;
        run_cycle(2'b11);
        flush = 1'b0;
        clear_inputs();
        set_slot(0, 32'h50c, 8'h0c, alu_c, 5'd12, 5'd0, 1, 0, a, 1, 0, 0);
        run_cycle(2'b11);

        // Reset in the middle of a run
        reset_dut();
        set_slot(0, 32'h600, 8'h01, alu_c, a, b, 1, 1, 5'd28, 1, 0, 0);
        set_slot(1, 32'h604, 8'h02, alu_c, c, d, 1, 1, 5'd29, 1, 0, 0);
        run_cycle(2'b11);

        $display("TEST PASSED");
        $finish;
    end
endmodule

// ==== project.f ====
design/dispatch_pkg.sv
design/dispatch_if.sv
design/regfile.sv
design/issue_checker.sv
design/operand_collector.sv
design/issue_register.sv
design/dispatch_top.sv
tb/dispatch_properties.sv
tb/tb_dispatch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dispatch
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
